//--- rtl/fb_pkg.sv
/* frame geometry, bus widths and shared types for the frame buffer
 * FIFO_DEPTH must fit in CREDIT_W bits, FRAME_WORDS must fit in ADDR_W bits
 */
`default_nettype none

package fb_pkg;

    // ------------------------------------------------------------
    // frame geometry
    // ------------------------------------------------------------

    // pixels per line
    localparam int H_DISPLAY   = 16;
    // lines per frame
    localparam int V_DISPLAY   = 8;
    localparam int FRAME_WORDS = H_DISPLAY * V_DISPLAY;

    // ------------------------------------------------------------
    // sram and pixel widths
    // ------------------------------------------------------------

    localparam int ADDR_W = 10;
    localparam int DATA_W = 16;
    // colour sits in the low bits of each word
    localparam int RGB_W  = 12;

    // prefetch slots, also the credit count after reset
    localparam int FIFO_DEPTH = 8;
    // holds 0 .. FIFO_DEPTH
    localparam int CREDIT_W   = 4;

    // ------------------------------------------------------------
    // request types
    // ------------------------------------------------------------

    // one sram cycle, read and write never both set
    typedef struct packed {
        logic              read;
        logic              write;
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] writedata;
    } sram_req_t;

    // host master pins, held until waitrequest drops
    typedef struct packed {
        logic              read;
        logic              write;
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] writedata;
    } host_req_t;

    // owner of the sram read in flight
    typedef enum logic [1:0] {
        OWNER_NONE,
        OWNER_SCAN,
        OWNER_HOST
    } rd_owner_e;

endpackage

`default_nettype wire

//--- rtl/fb_scan_reader.sv
/* raster prefetch reader, one sram read per held credit
 * reads start one cycle after reset and are granted in the cycle they are issued
 */
`timescale 1ns/10ps
`default_nettype none

module fb_scan_reader (
    input  wire               sys_clk,
    input  wire               sys_rst,
    input  wire               credit_return,
    output fb_pkg::sram_req_t scan_req
);

    // ------------------------------------------------------------
    // signals
    // ------------------------------------------------------------

    logic                        scan_en;
    logic                        issue;
    logic                        h_last;
    logic                        v_last;
    logic [fb_pkg::CREDIT_W-1:0] credits;
    logic [fb_pkg::CREDIT_W-1:0] credit_add;
    logic [fb_pkg::CREDIT_W-1:0] credit_sub;
    logic [fb_pkg::ADDR_W-1:0]   h_cnt;
    logic [fb_pkg::ADDR_W-1:0]   v_cnt;
    logic [fb_pkg::ADDR_W-1:0]   line_base;

    // ------------------------------------------------------------
    // credit counter
    // ------------------------------------------------------------

    // a returning credit can be spent in its own cycle
    assign issue = scan_en && ((credits != '0) || credit_return);

    assign credit_add = {{(fb_pkg::CREDIT_W-1){1'b0}}, credit_return};
    assign credit_sub = {{(fb_pkg::CREDIT_W-1){1'b0}}, issue};

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            scan_en <= 1'b0;
            credits <= fb_pkg::FIFO_DEPTH[fb_pkg::CREDIT_W-1:0];
        end else begin
            // keeps the sram quiet in the first cycle out of reset
            scan_en <= 1'b1;
            // return and spend may land together
            credits <= credits + credit_add - credit_sub;
        end
    end

    // ------------------------------------------------------------
    // raster address
    // ------------------------------------------------------------

    assign h_last = (h_cnt == fb_pkg::H_DISPLAY - 1);
    assign v_last = (v_cnt == fb_pkg::V_DISPLAY - 1);

    // line_base tracks v_cnt * H_DISPLAY without a multiplier
    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            h_cnt     <= '0;
            v_cnt     <= '0;
            line_base <= '0;
        end else if (issue) begin
            if (h_last) begin
                h_cnt <= '0;
                if (v_last) begin
                    // frame end, back to word 0
                    v_cnt     <= '0;
                    line_base <= '0;
                end else begin
                    v_cnt     <= v_cnt + 1'b1;
                    line_base <= line_base + fb_pkg::H_DISPLAY[fb_pkg::ADDR_W-1:0];
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // read only, write data unused on this path
    assign scan_req.read      = issue;
    assign scan_req.write     = 1'b0;
    assign scan_req.address   = line_base + h_cnt;
    assign scan_req.writedata = '0;

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    // fifo never hands back more credits than slots exist
    a_credit_bound: assert property (@(posedge sys_clk) disable iff (sys_rst)
        (credits <= fb_pkg::FIFO_DEPTH[fb_pkg::CREDIT_W-1:0]) &&
        !(credit_return && (credits == fb_pkg::FIFO_DEPTH[fb_pkg::CREDIT_W-1:0])));

endmodule

`default_nettype wire

//--- rtl/fb_host_port.sv
/* single outstanding host request, avalon style waitrequest handshake
 * the master must hold its request until waitrequest is low
 */
`timescale 1ns/10ps
`default_nettype none

module fb_host_port (
    input  wire               sys_clk,
    input  wire               sys_rst,
    input  wire               host_grant,
    input  wire               host_rdata_valid,
    input  wire               [fb_pkg::DATA_W-1:0] rdata,
    input  wire fb_pkg::host_req_t host,
    output fb_pkg::sram_req_t host_sram_req,
    output logic              host_waitrequest,
    output logic [fb_pkg::DATA_W-1:0] host_readdata,
    output logic              host_readdata_valid
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_DATA
    } host_state_e;

    host_state_e               state;
    fb_pkg::sram_req_t         req_q;
    logic [fb_pkg::DATA_W-1:0] rdata_q;
    logic                      host_active;

    assign host_active = host.read || host.write;

    // ------------------------------------------------------------
    // request fsm
    // ------------------------------------------------------------

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (host_active) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    // writes finish at the grant edge
                    if (host_grant) begin
                        state <= req_q.read ? WAIT_DATA : IDLE;
                    end
                end
                WAIT_DATA: begin
                    // data is back exactly one cycle after grant
                    if (host_rdata_valid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // capture the held request
    always_ff @(posedge sys_clk) begin
        if ((state == IDLE) && host_active) begin
            req_q.read      <= host.read;
            req_q.write     <= host.write;
            req_q.address   <= host.address;
            req_q.writedata <= host.writedata;
        end
    end

    // only present to the arbiter while pending
    always_comb begin
        host_sram_req       = req_q;
        host_sram_req.read  = (state == REQ) && req_q.read;
        host_sram_req.write = (state == REQ) && req_q.write;
    end

    // low on grant, also low when idle with nothing asked
    assign host_waitrequest = !(((state == REQ) && host_grant) ||
                                ((state == IDLE) && !host_active));

    // ------------------------------------------------------------
    // read return
    // ------------------------------------------------------------

    assign host_readdata_valid = (state == WAIT_DATA) && host_rdata_valid;

    // last word kept stable after the valid pulse
    always_ff @(posedge sys_clk) begin
        if (host_readdata_valid) begin
            rdata_q <= rdata;
        end
    end

    assign host_readdata = host_readdata_valid ? rdata : rdata_q;

    // arbiter must return the word next cycle, no new request meanwhile
    a_read_return: assert property (@(posedge sys_clk) disable iff (sys_rst)
        (state == WAIT_DATA) |-> host_rdata_valid);

endmodule

`default_nettype wire

//--- rtl/fb_sram_arbiter.sv
/* fixed priority sram arbiter, scan reads always win
 * assumes one cycle sram read latency, rdata is shared by both owners
 */
`timescale 1ns/10ps
`default_nettype none

module fb_sram_arbiter (
    input  wire                        sys_clk,
    input  wire                        sys_rst,
    input  wire fb_pkg::sram_req_t     scan_req,
    input  wire fb_pkg::sram_req_t     host_sram_req,
    input  wire [fb_pkg::DATA_W-1:0]   sram_readdata,
    output fb_pkg::sram_req_t          sram_req,
    output logic                       host_grant,
    output logic                       scan_rdata_valid,
    output logic                       host_rdata_valid,
    output logic [fb_pkg::DATA_W-1:0]  rdata
);

    // ------------------------------------------------------------
    // grant and sram drive
    // ------------------------------------------------------------

    logic             host_valid;
    fb_pkg::rd_owner_e owner_nxt;
    fb_pkg::rd_owner_e owner_q;

    assign host_valid = host_sram_req.read || host_sram_req.write;

    // scan needs no grant, it owns any cycle it asks for
    assign host_grant = host_valid && !scan_req.read;

    // idle host request has read and write low, safe as default
    assign sram_req = scan_req.read ? scan_req : host_sram_req;

    // ------------------------------------------------------------
    // read owner tag
    // ------------------------------------------------------------

    always_comb begin
        if (scan_req.read) begin
            owner_nxt = fb_pkg::OWNER_SCAN;
        end else if (host_grant && host_sram_req.read) begin
            owner_nxt = fb_pkg::OWNER_HOST;
        end else begin
            // writes and idle cycles return nothing
            owner_nxt = fb_pkg::OWNER_NONE;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            owner_q <= fb_pkg::OWNER_NONE;
        end else begin
            owner_q <= owner_nxt;
        end
    end

    // steer the returning word
    assign scan_rdata_valid = (owner_q == fb_pkg::OWNER_SCAN);
    assign host_rdata_valid = (owner_q == fb_pkg::OWNER_HOST);
    assign rdata            = sram_readdata;

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    // a cycle on the sram pins is a read or a write, never both
    a_one_op: assert property (@(posedge sys_clk) disable iff (sys_rst)
        !(sram_req.read && sram_req.write));

endmodule

`default_nettype wire

//--- rtl/fb_prefetch_fifo.sv
/* pixel prefetch fifo, head word shown combinationally
 * relies on the credit loop to never be pushed when full
 */
`timescale 1ns/10ps
`default_nettype none

module fb_prefetch_fifo (
    input  wire                        sys_clk,
    input  wire                        sys_rst,
    input  wire                        push,
    input  wire [fb_pkg::DATA_W-1:0]   push_data,
    input  wire                        pixel_read,
    output logic [fb_pkg::RGB_W-1:0]   pixel_rgb,
    output logic                       pixel_valid,
    output logic                       pixel_start,
    output logic                       credit_return
);

    // ------------------------------------------------------------
    // storage and pointers
    // ------------------------------------------------------------

    logic [fb_pkg::DATA_W-1:0]             mem [fb_pkg::FIFO_DEPTH];
    logic [$clog2(fb_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(fb_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    logic [fb_pkg::CREDIT_W-1:0]           count;
    logic                                  pop;
    logic                                  full;

    assign full = (count == fb_pkg::FIFO_DEPTH[fb_pkg::CREDIT_W-1:0]);
    assign pop  = pixel_read && pixel_valid;

    always_ff @(posedge sys_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // wrap written out for non power of two depths
            if (push) begin
                wr_ptr <= (wr_ptr == fb_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == fb_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // display side
    // ------------------------------------------------------------

    assign pixel_valid = (count != '0);
    assign pixel_rgb   = mem[rd_ptr][fb_pkg::RGB_W-1:0];

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            pixel_start   <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            // sticky once the buffer has filled up
            if (full) begin
                pixel_start <= 1'b1;
            end
            // one credit back per popped pixel
            credit_return <= pop;
        end
    end

    // overflow would mean the reader spent credits it did not hold
    a_no_overflow: assert property (@(posedge sys_clk) disable iff (sys_rst)
        !(push && full));

endmodule

`default_nettype wire

//--- rtl/frame_buffer_top.sv
/* frame buffer top, everything on sys_clk
 * sram must return read data one cycle after the read, byte enables are implied all ones
 */
`timescale 1ns/10ps
`default_nettype none

module frame_buffer_top (
    input  wire                        sys_clk,
    input  wire                        sys_rst,
    // host master
    input  wire fb_pkg::host_req_t     host,
    output logic                       host_waitrequest,
    output logic [fb_pkg::DATA_W-1:0]  host_readdata,
    output logic                       host_readdata_valid,
    // display stream
    input  wire                        pixel_read,
    output logic [fb_pkg::RGB_W-1:0]   pixel_rgb,
    output logic                       pixel_valid,
    output logic                       pixel_start,
    // sram pins
    output fb_pkg::sram_req_t          sram_req,
    input  wire [fb_pkg::DATA_W-1:0]   sram_readdata
);

    // ------------------------------------------------------------
    // internal nets
    // ------------------------------------------------------------

    fb_pkg::sram_req_t         scan_req;
    fb_pkg::sram_req_t         host_sram_req;
    logic                      host_grant;
    logic                      scan_rdata_valid;
    logic                      host_rdata_valid;
    logic [fb_pkg::DATA_W-1:0] rdata;
    logic                      credit_return;

    fb_scan_reader fb_scan_reader_i (
        .sys_clk       (sys_clk),
        .sys_rst       (sys_rst),
        .credit_return (credit_return),
        .scan_req      (scan_req)
    );

    fb_host_port fb_host_port_i (
        .sys_clk             (sys_clk),
        .sys_rst             (sys_rst),
        .host_grant          (host_grant),
        .host_rdata_valid    (host_rdata_valid),
        .rdata               (rdata),
        .host                (host),
        .host_sram_req       (host_sram_req),
        .host_waitrequest    (host_waitrequest),
        .host_readdata       (host_readdata),
        .host_readdata_valid (host_readdata_valid)
    );

    fb_sram_arbiter fb_sram_arbiter_i (
        .sys_clk          (sys_clk),
        .sys_rst          (sys_rst),
        .scan_req         (scan_req),
        .host_sram_req    (host_sram_req),
        .sram_readdata    (sram_readdata),
        .sram_req         (sram_req),
        .host_grant       (host_grant),
        .scan_rdata_valid (scan_rdata_valid),
        .host_rdata_valid (host_rdata_valid),
        .rdata            (rdata)
    );

    // scan words land here, credits flow back to the reader
    fb_prefetch_fifo fb_prefetch_fifo_i (
        .sys_clk       (sys_clk),
        .sys_rst       (sys_rst),
        .push          (scan_rdata_valid),
        .push_data     (rdata),
        .pixel_read    (pixel_read),
        .pixel_rgb     (pixel_rgb),
        .pixel_valid   (pixel_valid),
        .pixel_start   (pixel_start),
        .credit_return (credit_return)
    );

endmodule

`default_nettype wire

//--- test/sram_model.sv
/* behavioral synchronous sram, one cycle read latency, no byte enables
 * contents start unknown, readdata holds its last word between reads
 */
`timescale 1ns/10ps
`default_nettype none

module sram_model (
    input  wire                        sys_clk,
    input  wire fb_pkg::sram_req_t     sram_req,
    output logic [fb_pkg::DATA_W-1:0]  sram_readdata
);

    // ------------------------------------------------------------
    // storage
    // ------------------------------------------------------------

    // full address space, not just the visible frame
    logic [fb_pkg::DATA_W-1:0] mem [2**fb_pkg::ADDR_W];

    // write lands at the edge it is presented
    always_ff @(posedge sys_clk) begin
        if (sram_req.write) begin
            mem[sram_req.address] <= sram_req.writedata;
        end
    end

    // read word appears one cycle after the request
    always_ff @(posedge sys_clk) begin
        if (sram_req.read) begin
            sram_readdata <= mem[sram_req.address];
        end
    end

endmodule

`default_nettype wire

//--- test/tb_frame_buffer.sv
/* frame buffer testbench, host ops come from a table applied in a loop
 * display pops at random with a fixed seed, first popped frame is stale and unchecked
 */
`timescale 1ns/10ps
`default_nettype none

module tb_frame_buffer;

    localparam int HOST_TIMEOUT  = 200;
    localparam int START_TIMEOUT = 100;
    localparam int FRAME_TIMEOUT = 40 * fb_pkg::FRAME_WORDS;

    // one host operation with its expected read value
    typedef struct packed {
        logic                      is_write;
        logic [fb_pkg::ADDR_W-1:0] addr;
        logic [fb_pkg::DATA_W-1:0] wdata;
        logic [fb_pkg::DATA_W-1:0] expected;
    } host_op_t;

    logic                      sys_clk;
    logic                      sys_rst;
    fb_pkg::host_req_t         host;
    logic                      host_waitrequest;
    logic [fb_pkg::DATA_W-1:0] host_readdata;
    logic                      host_readdata_valid;
    logic                      pixel_read;
    logic [fb_pkg::RGB_W-1:0]  pixel_rgb;
    logic                      pixel_valid;
    logic                      pixel_start;
    fb_pkg::sram_req_t         sram_req;
    logic [fb_pkg::DATA_W-1:0] sram_readdata;

    host_op_t                  op_table [$];
    int                        live_first;
    int                        pix_count;
    int                        pop_mode;
    integer                    seed = 32'h448c_a53f;
    integer                    pop_rnd;
    logic [fb_pkg::DATA_W-1:0] exp_word;

    frame_buffer_top frame_buffer_top_i (
        .sys_clk             (sys_clk),
        .sys_rst             (sys_rst),
        .host                (host),
        .host_waitrequest    (host_waitrequest),
        .host_readdata       (host_readdata),
        .host_readdata_valid (host_readdata_valid),
        .pixel_read          (pixel_read),
        .pixel_rgb           (pixel_rgb),
        .pixel_valid         (pixel_valid),
        .pixel_start         (pixel_start),
        .sram_req            (sram_req),
        .sram_readdata       (sram_readdata)
    );

    sram_model sram_model_i (
        .sys_clk       (sys_clk),
        .sram_req      (sram_req),
        .sram_readdata (sram_readdata)
    );

    always #20 sys_clk = ~sys_clk;

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------

    // odd multiplier keeps every address distinct, also in the rgb bits
    function automatic logic [fb_pkg::DATA_W-1:0] word_pattern(input int addr);
        logic [31:0] prod;
        prod = addr * 32'h0000_02f1;
        return prod[fb_pkg::DATA_W-1:0] ^ 16'hc3a5;
    endfunction

    function automatic host_op_t make_op(input logic is_write, input int addr,
                                         input logic [fb_pkg::DATA_W-1:0] wdata,
                                         input logic [fb_pkg::DATA_W-1:0] expected);
        host_op_t op;
        op.is_write = is_write;
        op.addr     = addr[fb_pkg::ADDR_W-1:0];
        op.wdata    = wdata;
        op.expected = expected;
        return op;
    endfunction

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic mismatch(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
        $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, expected);
        abort_run();
    endtask

    task automatic timed_out(input string what);
        $display("Timeout: %s", what);
        abort_run();
    endtask

    task automatic build_op_table();
        int a;
        int k;
        // fill the whole frame
        for (a = 0; a < fb_pkg::FRAME_WORDS; a++) begin
            op_table.push_back(make_op(1'b1, a, word_pattern(a), '0));
        end
        // spread of read backs
        for (a = 0; a < fb_pkg::FRAME_WORDS; a += 9) begin
            op_table.push_back(make_op(1'b0, a, '0, word_pattern(a)));
        end
        op_table.push_back(make_op(1'b0, fb_pkg::FRAME_WORDS - 1, '0,
                                   word_pattern(fb_pkg::FRAME_WORDS - 1)));
        // overwrite, read, then restore
        op_table.push_back(make_op(1'b1, 5, 16'hbeef, '0));
        op_table.push_back(make_op(1'b0, 5, '0, 16'hbeef));
        op_table.push_back(make_op(1'b1, 5, word_pattern(5), '0));
        op_table.push_back(make_op(1'b0, 5, '0, word_pattern(5)));
        // reads mixed in with display traffic
        live_first = op_table.size();
        for (k = 0; k < 12; k++) begin
            a = (k * 37 + 3) % fb_pkg::FRAME_WORDS;
            op_table.push_back(make_op(1'b0, a, '0, word_pattern(a)));
        end
    endtask

    // hold the request until waitrequest drops, then check any read return
    task automatic apply_host_op(input host_op_t op);
        int waits;
        @(negedge sys_clk);
        host.read      = !op.is_write;
        host.write     = op.is_write;
        host.address   = op.addr;
        host.writedata = op.wdata;
        waits = 0;
        @(posedge sys_clk);
        while (host_waitrequest) begin
            waits++;
            if (waits > HOST_TIMEOUT) begin
                timed_out("host request was never accepted");
            end
            @(posedge sys_clk);
        end
        @(negedge sys_clk);
        host.read  = 1'b0;
        host.write = 1'b0;
        if (!op.is_write) begin
            @(posedge sys_clk);
            waits = 1;
            while (!host_readdata_valid) begin
                if (waits > HOST_TIMEOUT) begin
                    timed_out("host read data never came back");
                end
                @(posedge sys_clk);
                waits++;
            end
            assert (waits == 1) else mismatch("host_readdata_valid latency", waits, 1);
            assert (host_readdata === op.expected)
                else mismatch("host_readdata", host_readdata, op.expected);
        end
    endtask

    // ------------------------------------------------------------
    // display consumer
    // ------------------------------------------------------------

    // 0 stalled, 1 always reading, 2 random
    always @(negedge sys_clk) begin
        pop_rnd = $random(seed);
        case (pop_mode)
            0:       pixel_read = 1'b0;
            1:       pixel_read = 1'b1;
            default: pixel_read = pop_rnd[0];
        endcase
    end

    // pixel k is frame word k mod FRAME_WORDS
    always @(posedge sys_clk) begin
        if (!sys_rst && pixel_read && pixel_valid) begin
            if (pix_count >= fb_pkg::FRAME_WORDS) begin
                exp_word = word_pattern(pix_count % fb_pkg::FRAME_WORDS);
                assert (pixel_rgb === exp_word[fb_pkg::RGB_W-1:0])
                    else mismatch("pixel_rgb", pixel_rgb, exp_word[fb_pkg::RGB_W-1:0]);
            end
            pix_count++;
        end
    end

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------

    initial begin : main_seq
        int reads;
        int waits;
        int i;
        sys_clk    = 1'b0;
        sys_rst    = 1'b1;
        host       = '0;
        pixel_read = 1'b0;
        pop_mode   = 0;
        pix_count  = 0;
        build_op_table();
        repeat (10) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_rst = 1'b0;

        // quiet outputs out of reset
        @(posedge sys_clk);
        assert (!pixel_valid) else mismatch("pixel_valid", pixel_valid, 0);
        assert (!pixel_start) else mismatch("pixel_start", pixel_start, 0);
        assert (!host_readdata_valid)
            else mismatch("host_readdata_valid", host_readdata_valid, 0);
        assert (!sram_req.read) else mismatch("sram_req.read", sram_req.read, 0);
        assert (!sram_req.write) else mismatch("sram_req.write", sram_req.write, 0);
        assert (!host_waitrequest) else mismatch("host_waitrequest", host_waitrequest, 0);

        // prefetch fill with no pops
        reads = 0;
        waits = 0;
        while (!pixel_start) begin
            if (waits > START_TIMEOUT) begin
                timed_out("pixel_start never rose");
            end
            @(posedge sys_clk);
            waits++;
            if (sram_req.read) begin
                reads++;
            end
        end
        // credits gone, reader must stay idle
        repeat (2 * fb_pkg::FIFO_DEPTH) begin
            @(posedge sys_clk);
            if (sram_req.read) begin
                reads++;
            end
        end
        assert (reads == fb_pkg::FIFO_DEPTH) else mismatch("scan read count", reads,
                                                          fb_pkg::FIFO_DEPTH);
        assert (pixel_valid) else mismatch("pixel_valid", pixel_valid, 1);

        // writes and read backs, all sram cycles go to the host
        for (i = 0; i < live_first; i++) begin
            apply_host_op(op_table[i]);
        end

        // flush the stale frame, then check one frame at full rate
        @(posedge sys_clk);
        pop_mode = 1;
        waits = 0;
        while (pix_count < 2 * fb_pkg::FRAME_WORDS) begin
            if (waits > FRAME_TIMEOUT) begin
                timed_out("display did not pop two frames");
            end
            @(negedge sys_clk);
            waits++;
        end

        // random stalls with host reads mixed in
        @(posedge sys_clk);
        pop_mode = 2;
        for (i = live_first; i < op_table.size(); i++) begin
            apply_host_op(op_table[i]);
        end
        waits = 0;
        while (pix_count < 4 * fb_pkg::FRAME_WORDS) begin
            if (waits > FRAME_TIMEOUT) begin
                timed_out("display did not pop two more frames under random stalls");
            end
            @(negedge sys_clk);
            waits++;
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
rtl/fb_pkg.sv
rtl/fb_scan_reader.sv
rtl/fb_host_port.sv
rtl/fb_sram_arbiter.sv
rtl/fb_prefetch_fifo.sv
rtl/frame_buffer_top.sv
test/sram_model.sv
test/tb_frame_buffer.sv
